// ==== hw/sifhPkg.sv ====
package sifhPkg;

    localparam int SAMPLE_WIDTH      = 10;
    localparam int PIXEL_NUM         = 3;
    localparam int SAMPLES_PER_PIXEL = 2;
    localparam int FRAMES_PER_ACQ    = 2;
    localparam int SUM_WIDTH         = 12;

    // Four samples per pixel per acquisition, so the mean is a shift by two
    localparam int MEAN_SHIFT = $clog2(SAMPLES_PER_PIXEL * FRAMES_PER_ACQ);

    localparam int SAMPLE_IDX_WIDTH = 1;
    localparam int PIXEL_IDX_WIDTH  = 2;
    localparam int FRAME_IDX_WIDTH  = 1;
    localparam int RESULT_WIDTH     = PIXEL_NUM * SAMPLE_WIDTH;

    typedef logic [SAMPLE_WIDTH-1:0]     sampleT;
    typedef logic [SUM_WIDTH-1:0]        sumT;
    typedef logic [SAMPLE_IDX_WIDTH-1:0] sampleIdxT;
    typedef logic [PIXEL_IDX_WIDTH-1:0]  pixelIdxT;
    typedef logic [FRAME_IDX_WIDTH-1:0]  frameIdxT;
    typedef logic [RESULT_WIDTH-1:0]     resultT;   // Pixel 0 in the lowest bits

    // Terminal counts of the position counters
    localparam sampleIdxT LAST_SAMPLE = sampleIdxT'(SAMPLES_PER_PIXEL - 1);
    localparam pixelIdxT  LAST_PIXEL  = pixelIdxT'(PIXEL_NUM - 1);
    localparam frameIdxT  LAST_FRAME  = frameIdxT'(FRAMES_PER_ACQ - 1);

    typedef enum logic [1:0] {
        IDLE,
        COLLECT,
        FLUSH,
        PUBLISH
    } builderStateT;

endpackage

// ==== hw/sampleCounter.sv ====
`timescale 1ns/1ns

module sampleCounter (
    input  logic              clk,
    input  logic              rstN,
    input  logic              wrEn,
    output sifhPkg::pixelIdxT pixelIdx,
    output sifhPkg::frameIdxT frameIdx,
    output logic              pairEnd,
    output logic              acqEnd
);
    import sifhPkg::*;

    sampleIdxT sampleCnt;
    pixelIdxT  pixelCnt;
    frameIdxT  frameCnt;
    logic      lastSample;
    logic      lastPixel;
    logic      lastFrame;

    assign lastSample = (sampleCnt == LAST_SAMPLE);
    assign lastPixel  = (pixelCnt == LAST_PIXEL);
    assign lastFrame  = (frameCnt == LAST_FRAME);

    assign pairEnd = wrEn && lastSample;
    assign acqEnd  = pairEnd && lastPixel && lastFrame;   // Counters wrap on this strobe

    assign pixelIdx = pixelCnt;
    assign frameIdx = frameCnt;

    // Order is frame, then pixel, then sample
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            frameCnt  <= '0;
        end else if (wrEn) begin
            if (lastSample) begin
                sampleCnt <= '0;
                if (lastPixel) begin
                    pixelCnt <= '0;
                    frameCnt <= lastFrame ? '0 : frameCnt + 1'b1;
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/hisBuilderFsm.sv ====
`timescale 1ns/1ns

module hisBuilderFsm (
    input  logic clk,
    input  logic rstN,
    input  logic wrEn,
    input  logic acqEnd,
    output logic publish
);
    import sifhPkg::*;

    builderStateT state;
    builderStateT nextState;
    logic         strobeSeen;   // A new acquisition started while flushing

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (wrEn) begin
                    nextState = COLLECT;
                end
            end
            COLLECT: begin
                if (acqEnd) begin
                    nextState = FLUSH;
                end
            end
            FLUSH: begin
                nextState = PUBLISH;   // Last pair sum lands in the store here
            end
            PUBLISH: begin
                if (wrEn || strobeSeen) begin
                    nextState = COLLECT;
                end else begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            strobeSeen <= 1'b0;
        end else begin
            strobeSeen <= (state == FLUSH) && wrEn;
        end
    end

    // The pulse follows the PUBLISH cycle, so the packer samples the store
    // at the third edge after the last strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            publish <= 1'b0;
        end else begin
            publish <= (state == PUBLISH);
        end
    end

endmodule

// ==== hw/samplePairAdder.sv ====
`timescale 1ns/1ns

module samplePairAdder (
    input  logic              clk,
    input  logic              rstN,
    input  logic              wrEn,
    input  sifhPkg::sampleT   data,
    input  logic              pairEnd,
    input  sifhPkg::pixelIdxT pixelIdx,
    input  sifhPkg::frameIdxT frameIdx,
    output logic              pairValid,
    output sifhPkg::sumT      pairSum,
    output sifhPkg::pixelIdxT pairPixel,
    output sifhPkg::frameIdxT pairFrame
);
    import sifhPkg::*;

    sampleT firstSample;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pairValid <= 1'b0;
        end else begin
            pairValid <= wrEn && pairEnd;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn && !pairEnd) begin
            firstSample <= data;
        end
        if (wrEn && pairEnd) begin
            pairSum   <= sumT'(firstSample) + sumT'(data);
            pairPixel <= pixelIdx;   // Tag travels with the sum
            pairFrame <= frameIdx;
        end
    end

endmodule

// ==== hw/pixelAccumStore.sv ====
`timescale 1ns/1ns

module pixelAccumStore (
    input  logic              clk,
    input  logic              rstN,
    input  logic              pairValid,
    input  sifhPkg::sumT      pairSum,
    input  sifhPkg::pixelIdxT pairPixel,
    input  sifhPkg::frameIdxT pairFrame,
    output sifhPkg::sumT      pixelSum0,
    output sifhPkg::sumT      pixelSum1,
    output sifhPkg::sumT      pixelSum2
);
    import sifhPkg::*;

    sumT  sumMem [PIXEL_NUM];
    logic firstFrame;

    assign firstFrame = (pairFrame == '0);   // Frame 0 restarts the entry

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < PIXEL_NUM; i++) begin
                sumMem[i] <= '0;
            end
        end else if (pairValid) begin
            for (int i = 0; i < PIXEL_NUM; i++) begin
                if (pairPixel == pixelIdxT'(i)) begin
                    if (firstFrame) begin
                        sumMem[i] <= pairSum;
                    end else begin
                        sumMem[i] <= sumMem[i] + pairSum;
                    end
                end
            end
        end
    end

    assign pixelSum0 = sumMem[0];
    assign pixelSum1 = sumMem[1];
    assign pixelSum2 = sumMem[2];

endmodule

// ==== hw/resultPacker.sv ====
`timescale 1ns/1ns

module resultPacker (
    input  logic             clk,
    input  logic             rstN,
    input  logic             publish,
    input  sifhPkg::sumT     pixelSum0,
    input  sifhPkg::sumT     pixelSum1,
    input  sifhPkg::sumT     pixelSum2,
    output sifhPkg::resultT  result,
    output logic             resultValid
);
    import sifhPkg::*;

    sumT    sums [PIXEL_NUM];
    resultT meanWord;

    assign sums[0] = pixelSum0;
    assign sums[1] = pixelSum1;
    assign sums[2] = pixelSum2;

    // The truncated mean is at most 1023 and fits a sample slot
    always_comb begin
        meanWord = '0;
        for (int i = 0; i < PIXEL_NUM; i++) begin
            meanWord[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sampleT'(sums[i] >> MEAN_SHIFT);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= publish;
            if (publish) begin
                result <= meanWord;   // Held until the next acquisition
            end
        end
    end

endmodule

// ==== hw/hisBuilderTop.sv ====
`timescale 1ns/1ns

module hisBuilderTop (
    input  logic            clk,
    input  logic            rstN,
    input  logic            wrEn,
    input  sifhPkg::sampleT data,
    output sifhPkg::resultT result,
    output logic            resultValid
);
    import sifhPkg::*;

    pixelIdxT pixelIdx;
    frameIdxT frameIdx;
    logic     pairEnd;
    logic     acqEnd;
    logic     publish;
    logic     pairValid;
    sumT      pairSum;
    pixelIdxT pairPixel;
    frameIdxT pairFrame;
    sumT      pixelSum0;
    sumT      pixelSum1;
    sumT      pixelSum2;

    sampleCounter sampleCounterU0 (
        .clk      (clk),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .pixelIdx (pixelIdx),
        .frameIdx (frameIdx),
        .pairEnd  (pairEnd),
        .acqEnd   (acqEnd)
    );

    hisBuilderFsm hisBuilderFsmU0 (
        .clk     (clk),
        .rstN    (rstN),
        .wrEn    (wrEn),
        .acqEnd  (acqEnd),
        .publish (publish)
    );

    samplePairAdder samplePairAdderU0 (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .data      (data),
        .pairEnd   (pairEnd),
        .pixelIdx  (pixelIdx),
        .frameIdx  (frameIdx),
        .pairValid (pairValid),
        .pairSum   (pairSum),
        .pairPixel (pairPixel),
        .pairFrame (pairFrame)
    );

    pixelAccumStore pixelAccumStoreU0 (
        .clk       (clk),
        .rstN      (rstN),
        .pairValid (pairValid),
        .pairSum   (pairSum),
        .pairPixel (pairPixel),
        .pairFrame (pairFrame),
        .pixelSum0 (pixelSum0),
        .pixelSum1 (pixelSum1),
        .pixelSum2 (pixelSum2)
    );

    resultPacker resultPackerU0 (
        .clk         (clk),
        .rstN        (rstN),
        .publish     (publish),
        .pixelSum0   (pixelSum0),
        .pixelSum1   (pixelSum1),
        .pixelSum2   (pixelSum2),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

// ==== verification/hisBuilderTb.sv ====
`timescale 1ns/1ns

module hisBuilderTb;
    import sifhPkg::*;

    localparam int CLK_PERIOD        = 10;
    localparam int RESET_CYCLES      = 8;
    localparam int IDLE_CYCLES       = 20;
    localparam int PHASE_GAP         = 5;
    localparam int DRAIN_CYCLES      = 8;
    localparam int TAIL_CYCLES       = 10;
    localparam int MAX_GAP           = 3;
    localparam int VALID_DELAY       = 4;
    localparam int SAMPLES_PER_ACQ   = PIXEL_NUM * SAMPLES_PER_PIXEL * FRAMES_PER_ACQ;
    localparam int MEAN_DIVISOR      = SAMPLES_PER_PIXEL * FRAMES_PER_ACQ;
    localparam int BACK_TO_BACK_ACQ  = 5;
    localparam int GAPPED_ACQ        = 4;
    localparam int NUM_ACQ           = BACK_TO_BACK_ACQ + GAPPED_ACQ;
    localparam int TOTAL_STROBES     = NUM_ACQ * SAMPLES_PER_ACQ;
    localparam int TOTAL_GAPS        = GAPPED_ACQ * SAMPLES_PER_ACQ * MAX_GAP + RESET_CYCLES
                                     + IDLE_CYCLES + 2 * PHASE_GAP + DRAIN_CYCLES + TAIL_CYCLES;
    localparam int WATCHDOG_NS       = (TOTAL_STROBES + TOTAL_GAPS) * CLK_PERIOD * 2;
    localparam bit [31:0] RANDOM_SEED = 32'hf206;

    logic   clk = 1'b0;
    logic   rstN;
    logic   wrEn;
    sampleT data;
    resultT result;
    logic   resultValid;

    sampleT acqSamples [SAMPLES_PER_ACQ];   // Frame, then pixel, then sample

    int                     strobeIdx;
    int                     pixelAcc [PIXEL_NUM];
    resultT                 expQ [$];
    logic [VALID_DELAY-1:0] validPipe;       // Last strobe of each acquisition delayed to its valid cycle
    resultT                 expectedHead;
    int                     resultsSeen;

    always #(CLK_PERIOD / 2) clk = ~clk;

    hisBuilderTop u_dut (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .data        (data),
        .result      (result),
        .resultValid (resultValid)
    );

    function automatic void reportFailure(string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endfunction

    function automatic string describeResult(resultT word);
        return $sformatf("%0d/%0d/%0d", word[0*SAMPLE_WIDTH +: SAMPLE_WIDTH],
                         word[1*SAMPLE_WIDTH +: SAMPLE_WIDTH],
                         word[2*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
    endfunction

    function automatic int sampleIndex(int frame, int pixel, int sample);
        return (frame * PIXEL_NUM + pixel) * SAMPLES_PER_PIXEL + sample;
    endfunction

    // Reference model that tracks position by the strobe count only
    always @(posedge clk or negedge rstN) begin
        logic   lastStrobe;
        int     pixel;
        resultT meanWord;
        if (!rstN) begin
            strobeIdx = 0;
            for (int i = 0; i < PIXEL_NUM; i++) begin
                pixelAcc[i] = 0;
            end
            expQ.delete();
            validPipe     <= '0;
            expectedHead  <= '0;
            resultsSeen   <= 0;
        end else begin
            lastStrobe = 1'b0;
            if (resultValid) begin
                if (expQ.size() > 0) begin
                    void'(expQ.pop_front());
                end
                resultsSeen <= resultsSeen + 1;
            end
            if (wrEn) begin
                pixel = (strobeIdx / SAMPLES_PER_PIXEL) % PIXEL_NUM;
                pixelAcc[pixel] += int'(data);
                lastStrobe = (strobeIdx == SAMPLES_PER_ACQ - 1);
                strobeIdx = lastStrobe ? 0 : strobeIdx + 1;
                if (lastStrobe) begin
                    meanWord = '0;
                    for (int i = 0; i < PIXEL_NUM; i++) begin
                        meanWord[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] =
                            sampleT'(pixelAcc[i] / MEAN_DIVISOR);   // Truncating mean
                        pixelAcc[i] = 0;
                    end
                    expQ.push_back(meanWord);
                end
            end
            validPipe     <= {validPipe[VALID_DELAY-2:0], lastStrobe};
            expectedHead  <= (expQ.size() > 0) ? expQ[0] : '0;
        end
    end

    validTimingA: assert property (@(posedge clk) disable iff (!rstN)
        resultValid == validPipe[VALID_DELAY-1])
        else reportFailure($sformatf("resultValid is %0b, expected %0b",
                                     resultValid, validPipe[VALID_DELAY-1]));

    idleResultA: assert property (@(posedge clk) disable iff (!rstN)
        (resultsSeen == 0 && !resultValid) |-> (result == '0))
        else reportFailure($sformatf("result is %h before any publication", result));

    resultMatchA: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> (result == expectedHead))
        else reportFailure($sformatf("result means %s, expected %s",
                                     describeResult(result), describeResult(expectedHead)));

    task automatic driveIdle(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            wrEn = 1'b0;
            data = sampleT'($urandom_range(0, 1023));   // Ignored without a strobe
        end
    endtask

    task automatic driveStrobe(sampleT value);
        @(posedge clk);
        #1;
        wrEn = 1'b1;
        data = value;
    endtask

    task automatic sendAcquisition(int maxGap);
        int gapLen;
        for (int k = 0; k < SAMPLES_PER_ACQ; k++) begin
            driveStrobe(acqSamples[k]);
            if (maxGap > 0) begin
                gapLen = $urandom_range(0, maxGap);
                driveIdle(gapLen);
            end
        end
    endtask

    task automatic setSample(int frame, int pixel, int sample, int value);
        acqSamples[sampleIndex(frame, pixel, sample)] = sampleT'(value);
    endtask

    // Pixel 0 carries the reference values, the others check truncation
    task automatic loadDirected();
        setSample(0, 0, 0, 108);
        setSample(0, 0, 1, 511);
        setSample(1, 0, 0, 1023);
        setSample(1, 0, 1, 1023);
        setSample(0, 1, 0, 0);
        setSample(0, 1, 1, 1);
        setSample(1, 1, 0, 2);
        setSample(1, 1, 1, 3);
        setSample(0, 2, 0, 1023);
        setSample(0, 2, 1, 1023);
        setSample(1, 2, 0, 1023);
        setSample(1, 2, 1, 1022);
    endtask

    task automatic loadRandom();
        for (int k = 0; k < SAMPLES_PER_ACQ; k++) begin
            acqSamples[k] = sampleT'($urandom_range(0, 1023));
        end
    endtask

    task automatic loadAllMax();
        for (int k = 0; k < SAMPLES_PER_ACQ; k++) begin
            acqSamples[k] = sampleT'(1023);
        end
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        rstN = 1'b0;
        wrEn = 1'b0;
        data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;
        driveIdle(IDLE_CYCLES);   // Quiet output after reset

        // Each acquisition starts on the cycle after the previous last strobe
        loadDirected();
        sendAcquisition(0);
        loadRandom();
        sendAcquisition(0);
        loadAllMax();
        sendAcquisition(0);
        driveIdle(PHASE_GAP);

        // Same directed data with idle gaps must give the same means
        loadDirected();
        sendAcquisition(MAX_GAP);
        repeat (GAPPED_ACQ - 1) begin
            loadRandom();
            sendAcquisition(MAX_GAP);
        end
        driveIdle(PHASE_GAP);

        repeat (BACK_TO_BACK_ACQ - 3) begin
            loadRandom();
            sendAcquisition(0);
        end
        driveIdle(1);

        while (resultsSeen < NUM_ACQ) begin
            @(posedge clk);
        end
        repeat (TAIL_CYCLES) @(posedge clk);

        if (resultsSeen == NUM_ACQ && expQ.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            reportFailure($sformatf("%0d results seen, %0d expected, %0d still queued",
                                    resultsSeen, NUM_ACQ, expQ.size()));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns, %0d of %0d results seen",
                 WATCHDOG_NS, resultsSeen, NUM_ACQ);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

// ==== sim.f ====
hw/sifhPkg.sv
hw/sampleCounter.sv
hw/hisBuilderFsm.sv
hw/samplePairAdder.sv
hw/pixelAccumStore.sv
hw/resultPacker.sv
hw/hisBuilderTop.sv
verification/hisBuilderTb.sv

// ==== Makefile ====
# Verilator build and run of the pixel average testbench

TOP   := hisBuilderTb
BUILD := obj_dir
LOG   := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		--Mdir $(BUILD) -f sim.f

# The log decides pass or fail
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
